// File: design/alu_pkg.sv
// ALU shared definitions
// Word and float views, opcode map and unit ownership of each opcode

package alu_pkg;

	// ***********************************************************************
	// Widths
	// ***********************************************************************

	localparam int word_w = 32;
	localparam int man_w  = 23;                 // No hidden bit
	localparam int exp_w  = 8;                  // Two's complement exponent

	// Float value is man * 2^exp with the sign applied
	typedef struct packed {
		logic                    sign;
		logic signed [exp_w-1:0] exp;
		logic        [man_w-1:0] man;
	} float_t;

	// Same word seen as integer or as float by opcode
	typedef union packed {
		logic signed [word_w-1:0] i;
		float_t                   f;
	} alu_word_u;

	// Zero with the most negative exponent
	localparam float_t float_zero = '{sign: 1'b0, exp: {1'b1, {exp_w-1{1'b0}}}, man: '0};

	// Common exponent and signed mantissas of two operands
	typedef struct packed {
		logic signed [exp_w-1:0] exp;
		logic signed [man_w:0]   sm1;
		logic signed [man_w:0]   sm2;
	} aligned_t;

	// ***********************************************************************
	// Opcodes in the processor's numbering
	// ***********************************************************************

	typedef enum logic [5:0] {
		nop    = 6'd0,  lod    = 6'd1,  add    = 6'd2,  f_add   = 6'd3,
		mlt    = 6'd4,  div    = 6'd6,  mod    = 6'd8,  sgn     = 6'd9,
		f_sgn  = 6'd10, neg    = 6'd11, neg_m  = 6'd12, f_neg   = 6'd13,
		f_neg_m = 6'd14, abs   = 6'd15, abs_m  = 6'd16, f_abs   = 6'd17,
		f_abs_m = 6'd18, pst   = 6'd19, pst_m  = 6'd20, f_pst   = 6'd21,
		f_pst_m = 6'd22, nrm   = 6'd23, nrm_m  = 6'd24, and_op  = 6'd29,
		orr    = 6'd30, xor_op = 6'd31, inv    = 6'd32, inv_m   = 6'd33,
		lan    = 6'd34, lor    = 6'd35, lin    = 6'd36, lin_m   = 6'd37,
		les    = 6'd38, f_les  = 6'd39, gre    = 6'd40, f_gre   = 6'd41,
		equ    = 6'd42, shl    = 6'd43, shr    = 6'd44, srs     = 6'd45
	} alu_op_e;

	// Which unit owns the result
	typedef enum logic [1:0] {
		sel_int, sel_logic, sel_float, sel_none
	} unit_sel_e;

	function automatic unit_sel_e op_unit(alu_op_e op);
		case (op)
			add, mlt, div, mod, sgn, neg, neg_m, abs, abs_m,
			pst, pst_m, nrm, nrm_m:                  return sel_int;
			and_op, orr, xor_op, inv, inv_m, lan, lor, lin, lin_m,
			les, gre, equ, shl, shr, srs:            return sel_logic;
			f_add, f_sgn, f_neg, f_neg_m, f_abs, f_abs_m,
			f_pst, f_pst_m, f_les, f_gre:            return sel_float;
			default:                                 return sel_none; // NOP, LOD, unknown
		endcase
	endfunction

endpackage

// File: design/alu_int_arith.sv
// Integer arithmetic unit
// Two's complement sum, product, quotient, remainder and one-operand ops

`timescale 1ns/10ps

module alu_int_arith #(
	parameter logic signed [alu_pkg::word_w-1:0] nrm_gain = 64  // NRM divisor, non-zero
) (
	input  alu_pkg::alu_op_e  op,
	input  alu_pkg::alu_word_u in1,
	input  alu_pkg::alu_word_u in2,
	output alu_pkg::alu_word_u res
);

	import alu_pkg::*;

	logic signed [word_w-1:0] a, b;
	logic signed [word_w-1:0] opnd;             // One-operand source
	logic signed [word_w-1:0] b_safe;           // Divisor never zero
	logic                     div_zero;
	logic signed [word_w-1:0] sum, prod, quot, rem;
	logic signed [word_w-1:0] mag;
	logic                     use_in1;

	assign a = in1.i;
	assign b = in2.i;

	// _M forms work on in1
	assign use_in1 = (op == neg_m) || (op == abs_m) || (op == pst_m) || (op == nrm_m);
	assign opnd    = use_in1 ? a : b;

	// ***********************************************************************
	// Two-operand datapath
	// ***********************************************************************

	assign div_zero = (b == '0);
	assign b_safe   = div_zero ? word_w'(1) : b;   // Keeps divider defined

	assign sum  = a + b;                        // Wraps at 32 bits
	assign prod = a * b;                        // Low word only
	assign quot = a / b_safe;                   // Toward zero
	assign rem  = a % b_safe;                   // Sign follows dividend

	assign mag  = opnd[word_w-1] ? -opnd : opnd;

	// ***********************************************************************
	// Result select
	// ***********************************************************************

	always_comb begin
		res.i = '0;
		case (op)
			add:          res.i = sum;
			mlt:          res.i = prod;
			div:          res.i = div_zero ? '0 : quot;
			mod:          res.i = div_zero ? '0 : rem;
			// Sign of in1 applied to in2
			sgn:          res.i = (a[word_w-1] != b[word_w-1]) ? -b : b;
			neg, neg_m:   res.i = -opnd;
			abs, abs_m:   res.i = mag;
			pst, pst_m:   res.i = opnd[word_w-1] ? '0 : opnd;   // Clamp at zero
			nrm, nrm_m:   res.i = opnd / nrm_gain;              // Fixed divisor
			default:      res.i = '0;
		endcase
	end

endmodule

// File: design/alu_logic.sv
// Logic unit
// Bitwise, conditional, signed compare and shift operations

`timescale 1ns/10ps

module alu_logic (
	input  alu_pkg::alu_op_e  op,
	input  alu_pkg::alu_word_u in1,
	input  alu_pkg::alu_word_u in2,
	output alu_pkg::alu_word_u res
);

	import alu_pkg::*;

	localparam int sh_w = $clog2(word_w);

	logic signed [word_w-1:0] a, b;
	logic                     a_true, b_true;   // Non-zero is true
	logic                     big_shift;        // Amount 32 or more
	logic        [sh_w-1:0]   sh;

	assign a = in1.i;
	assign b = in2.i;

	assign a_true = (a != '0);
	assign b_true = (b != '0);

	// Any upper bit set puts the unsigned amount out of range
	assign big_shift = |b[word_w-1:sh_w];
	assign sh        = b[sh_w-1:0];

	always_comb begin
		res.i = '0;
		case (op)
			and_op: res.i = a & b;
			orr:    res.i = a | b;
			xor_op: res.i = a ^ b;
			inv:    res.i = ~b;
			inv_m:  res.i = ~a;
			// Conditionals give 1 or 0
			lan:    res.i = word_w'(a_true && b_true);
			lor:    res.i = word_w'(a_true || b_true);
			lin:    res.i = word_w'(!b_true);
			lin_m:  res.i = word_w'(!a_true);
			les:    res.i = word_w'(a < b);         // Signed compare
			gre:    res.i = word_w'(a > b);
			equ:    res.i = word_w'(a == b);
			// Shifts of in1 by in2
			shl:    res.i = big_shift ? '0 : a << sh;
			shr:    res.i = big_shift ? '0 : a >> sh;
			srs:    res.i = big_shift ? $signed({word_w{a[word_w-1]}}) : a >>> sh;
			default: res.i = '0;
		endcase
	end

endmodule

// File: design/alu_float_align.sv
// Float alignment
// Shifts the smaller-exponent mantissa down to the larger exponent
// and returns both mantissas signed

`timescale 1ns/10ps

module alu_float_align (
	input  alu_pkg::float_t   a,
	input  alu_pkg::float_t   b,
	output alu_pkg::aligned_t aligned
);

	import alu_pkg::*;

	logic signed [exp_w:0]   diff;              // a.exp - b.exp, no overflow
	logic                    b_big;             // b has the larger exponent
	logic        [exp_w:0]   shift_a, shift_b;
	logic        [man_w-1:0] man_a, man_b;

	assign diff  = a.exp - b.exp;
	assign b_big = diff[exp_w];

	// Only the smaller operand moves
	assign shift_a = b_big ? -diff : '0;
	assign shift_b = b_big ? '0 : diff;

	assign man_a = a.man >> shift_a;
	assign man_b = b.man >> shift_b;

	assign aligned.exp = b_big ? b.exp : a.exp;

	// Extra top bit holds the sign
	assign aligned.sm1 = a.sign ? -{1'b0, man_a} : {1'b0, man_a};
	assign aligned.sm2 = b.sign ? -{1'b0, man_b} : {1'b0, man_b};

endmodule

// File: design/alu_float_norm.sv
// Float normalizer
// Shifts the mantissa left until its top bit is set and lowers the exponent to match

`timescale 1ns/10ps

module alu_float_norm (
	input  alu_pkg::float_t raw,
	output alu_pkg::float_t norm
);

	import alu_pkg::*;

	localparam int sh_w = $clog2(man_w);

	logic [sh_w-1:0] shift;                     // Leading zero count
	logic            man_zero;

	assign man_zero = (raw.man == '0);

	// ***********************************************************************
	// Leading-one search
	// ***********************************************************************

	// Scan up from the LSB so the highest one wins
	always_comb begin
		shift = '0;
		for (int k = 0; k < man_w; k++) begin
			if (raw.man[k])
				shift = sh_w'(man_w - 1 - k);
		end
	end

	// ***********************************************************************
	// Output
	// ***********************************************************************

	always_comb begin
		if (man_zero) begin
			norm = float_zero;                  // Nothing to normalize
		end else begin
			norm.sign = raw.sign;
			norm.exp  = raw.exp - exp_w'(shift);   // Wraps in 8 bits
			norm.man  = raw.man << shift;
		end
	end

endmodule

// File: design/alu_float_arith.sv
// Float unit
// Sum with alignment and normalization, sign operations and compares

`timescale 1ns/10ps

module alu_float_arith (
	input  alu_pkg::alu_op_e  op,
	input  alu_pkg::alu_word_u in1,
	input  alu_pkg::alu_word_u in2,
	output alu_pkg::alu_word_u res
);

	import alu_pkg::*;

	aligned_t                aligned;
	logic signed [man_w+1:0] sum;               // One bit of headroom
	logic signed [man_w+1:0] sum_mag;
	float_t                  raw_sum, sum_norm;
	float_t                  opnd;              // One-operand source
	logic                    use_in1;

	alu_float_align i_align (
		.a       (in1.f),
		.b       (in2.f),
		.aligned (aligned)
	);

	// ***********************************************************************
	// F_ADD
	// ***********************************************************************

	assign sum     = aligned.sm1 + aligned.sm2;
	assign sum_mag = sum[man_w+1] ? -sum : sum;

	// Drop the LSB and bump the exponent to fit the carry
	assign raw_sum.sign = sum[man_w+1];
	assign raw_sum.exp  = aligned.exp + exp_w'(1);
	assign raw_sum.man  = sum_mag[man_w:1];

	alu_float_norm i_norm (
		.raw  (raw_sum),
		.norm (sum_norm)
	);

	// ***********************************************************************
	// One-operand forms and result select
	// ***********************************************************************

	assign use_in1 = (op == f_neg_m) || (op == f_abs_m) || (op == f_pst_m);
	assign opnd    = use_in1 ? in1.f : in2.f;

	always_comb begin
		res.i = '0;
		case (op)
			f_add:            res.f = sum_norm;
			f_sgn:            res.f = '{sign: in1.f.sign, exp: in2.f.exp, man: in2.f.man};
			f_neg, f_neg_m:   res.f = '{sign: ~opnd.sign, exp: opnd.exp, man: opnd.man};
			f_abs, f_abs_m:   res.f = '{sign: 1'b0, exp: opnd.exp, man: opnd.man};
			f_pst, f_pst_m:   res.f = opnd.sign ? float_zero : opnd;
			// Compare on the aligned signed mantissas
			f_les:            res.i = word_w'(aligned.sm1 < aligned.sm2);
			f_gre:            res.i = word_w'(aligned.sm1 > aligned.sm2);
			default:          res.i = '0;
		endcase
	end

endmodule

// File: design/alu_result_reg.sv
// Result select and register
// Picks the owning unit's word and holds it for one cycle

`timescale 1ns/10ps

module alu_result_reg (
	input  logic               clk,
	input  logic               arst_n,
	input  alu_pkg::alu_op_e   op,
	input  alu_pkg::alu_word_u in1,
	input  alu_pkg::alu_word_u in2,
	input  alu_pkg::alu_word_u int_res,
	input  alu_pkg::alu_word_u logic_res,
	input  alu_pkg::alu_word_u float_res,
	output alu_pkg::alu_word_u result
);

	import alu_pkg::*;

	alu_word_u sel_word;

	always_comb begin
		case (op_unit(op))
			sel_int:   sel_word = int_res;
			sel_logic: sel_word = logic_res;
			sel_float: sel_word = float_res;
			default: begin
				if (op == nop)
					sel_word = in2;             // Pass accumulator
				else if (op == lod)
					sel_word = in1;             // Pass memory operand
				else
					sel_word.i = '0;            // Unassigned code
			end
		endcase
	end

	// One cycle of latency, zero in reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			result <= '0;
		else
			result <= sel_word;
	end

endmodule

// File: design/alu.sv
// ALU top level
// Integer, logic and float units feeding one registered result

`timescale 1ns/10ps

module alu #(
	parameter logic signed [alu_pkg::word_w-1:0] nrm_gain = 64  // NRM divisor
) (
	input  logic               clk,
	input  logic               arst_n,
	input  alu_pkg::alu_op_e   op,
	input  alu_pkg::alu_word_u in1,             // Memory side
	input  alu_pkg::alu_word_u in2,             // Accumulator side
	output alu_pkg::alu_word_u result
);

	import alu_pkg::*;

	alu_word_u int_res;
	alu_word_u logic_res;
	alu_word_u float_res;

	// ***********************************************************************
	// Execution units, all combinational
	// ***********************************************************************

	alu_int_arith #(
		.nrm_gain (nrm_gain)
	) i_int_arith (
		.op  (op),
		.in1 (in1),
		.in2 (in2),
		.res (int_res)
	);

	alu_logic i_logic (
		.op  (op),
		.in1 (in1),
		.in2 (in2),
		.res (logic_res)
	);

	alu_float_arith i_float_arith (
		.op  (op),
		.in1 (in1),
		.in2 (in2),
		.res (float_res)
	);

	// ***********************************************************************
	// Output stage
	// ***********************************************************************

	alu_result_reg i_result_reg (
		.clk       (clk),
		.arst_n    (arst_n),
		.op        (op),
		.in1       (in1),
		.in2       (in2),
		.int_res   (int_res),
		.logic_res (logic_res),
		.float_res (float_res),
		.result    (result)
	);

endmodule

// File: verif/alu_model.svh
// ALU reference model
// Expected results for every kept opcode, written from the operation rules

`ifndef alu_model_svh
`define alu_model_svh

// Integer unit, zero for any other code
function automatic logic signed [31:0] int_result(alu_op_e op, logic signed [31:0] a,
		logic signed [31:0] b);
	logic signed [31:0] x;
	x = (op inside {neg_m, abs_m, pst_m, nrm_m}) ? a : b;    // _M forms read in1
	case (op)
		add: return a + b;
		mlt: return a * b;                      // Low word
		div: begin
			if (b == 0)
				return 0;                       // Zero divisor gives zero
			return a / b;
		end
		mod: begin
			if (b == 0)
				return 0;
			return a % b;
		end
		sgn:        return ((a < 0) == (b < 0)) ? b : -b;
		neg, neg_m: return -x;
		abs, abs_m: return (x < 0) ? -x : x;
		pst, pst_m: return (x < 0) ? 0 : x;
		nrm, nrm_m: return x / nrm_gain;        // Truncates toward zero
		default:    return 0;
	endcase
endfunction

// Logic, conditional, compare and shift
function automatic logic signed [31:0] logic_result(alu_op_e op, logic signed [31:0] a,
		logic signed [31:0] b);
	logic [31:0] amt;
	amt = b;                                    // Shift amount is unsigned
	case (op)
		and_op: return a & b;
		orr:    return a | b;
		xor_op: return a ^ b;
		inv:    return ~b;
		inv_m:  return ~a;
		lan:    return (a != 0 && b != 0) ? 1 : 0;
		lor:    return (a != 0 || b != 0) ? 1 : 0;
		lin:    return (b == 0) ? 1 : 0;
		lin_m:  return (a == 0) ? 1 : 0;
		les:    return (a < b) ? 1 : 0;
		gre:    return (a > b) ? 1 : 0;
		equ:    return (a == b) ? 1 : 0;
		shl:    return (amt > 31) ? 0 : a << amt;
		shr:    return (amt > 31) ? 0 : a >> amt;
		srs: begin
			if (amt > 31)
				return (a < 0) ? -1 : 0;        // All sign bits
			return a >>> amt;
		end
		default: return 0;
	endcase
endfunction

// Common exponent and signed mantissas
function automatic void align_operands(float_t x, float_t y, output int e,
		output int s1, output int s2);
	int ex, ey, mx, my;
	ex = x.exp;
	ey = y.exp;
	mx = x.man;
	my = y.man;
	if (ex >= ey) begin
		e  = ex;
		my = my >> (ex - ey);                   // Smaller one moves down
	end else begin
		e  = ey;
		mx = mx >> (ey - ex);
	end
	s1 = x.sign ? -mx : mx;
	s2 = y.sign ? -my : my;
endfunction

// Aligned sum, one bit dropped, then normalized
function automatic float_t float_sum(float_t x, float_t y);
	int     e, s1, s2, sum, mag, m, sh;
	float_t r;
	align_operands(x, y, e, s1, s2);
	sum = s1 + s2;
	mag = (sum < 0) ? -sum : sum;
	m   = (mag >> 1) & 32'h007f_ffff;
	if (m == 0)
		return float_zero;                      // Cancelled
	sh = 0;
	while (((m << sh) & 32'h0040_0000) == 0)
		sh++;
	r.sign = (sum < 0);
	r.exp  = 8'(e + 1 - sh);                    // Wraps in 8 bits
	r.man  = 23'(m << sh);
	return r;
endfunction

// Float unit, zero for any other code
function automatic alu_word_u float_result(alu_op_e op, float_t x, float_t y);
	alu_word_u r;
	float_t    o;
	int        e, s1, s2;
	r.i = 0;
	o   = (op inside {f_neg_m, f_abs_m, f_pst_m}) ? x : y;
	align_operands(x, y, e, s1, s2);
	case (op)
		f_add:          r.f = float_sum(x, y);
		f_sgn:          r.f = '{sign: x.sign, exp: y.exp, man: y.man};
		f_neg, f_neg_m: begin
			o.sign = ~o.sign;
			r.f    = o;
		end
		f_abs, f_abs_m: begin
			o.sign = 1'b0;
			r.f    = o;
		end
		f_pst, f_pst_m: r.f = o.sign ? float_zero : o;
		f_les:          r.i = (s1 < s2) ? 1 : 0;
		f_gre:          r.i = (s1 > s2) ? 1 : 0;
		default:        ;
	endcase
	return r;
endfunction

// Word a float op returns, compared field by field
function automatic logic is_float_op(alu_op_e op);
	return op inside {f_add, f_sgn, f_neg, f_neg_m, f_abs, f_abs_m, f_pst, f_pst_m};
endfunction

// Full ALU, NOP and LOD pass an operand
function automatic alu_word_u expected_word(alu_op_e op, alu_word_u a, alu_word_u b);
	alu_word_u r;
	alu_word_u f;
	if (op == nop)
		return b;
	if (op == lod)
		return a;
	f   = float_result(op, a.f, b.f);
	r.i = int_result(op, a.i, b.i) | logic_result(op, a.i, b.i) | f.i;   // Unknown code is zero
	return r;
endfunction

`endif

// File: verif/tb_alu.sv
// ALU testbench
// Random opcodes and operands every cycle, checked one cycle later
// against the reference model

`timescale 1ns/10ps

module tb_alu;

	import alu_pkg::*;

	localparam logic signed [word_w-1:0] nrm_gain = 64;
	localparam int reset_cycles = 8;
	localparam int n_ops        = 3000;         // Issued after reset
	localparam int n_directed   = 16;           // NOP, LOD and spare codes first

	logic      clk = 1'b0;
	logic      arst_n;
	alu_op_e   op;
	alu_word_u in1, in2, result;

	integer    seed;
	int        int_errors, float_errors;

	alu_op_e kept_ops[40] = '{nop, lod, add, f_add, mlt, div, mod, sgn, f_sgn, neg,
		neg_m, f_neg, f_neg_m, abs, abs_m, f_abs, f_abs_m, pst, pst_m, f_pst, f_pst_m,
		nrm, nrm_m, and_op, orr, xor_op, inv, inv_m, lan, lor, lin, lin_m, les, f_les,
		gre, f_gre, equ, shl, shr, srs};
	logic [5:0] spare_codes[8] = '{6'd5, 6'd7, 6'd25, 6'd26, 6'd28, 6'd46, 6'd55, 6'd63};

	`include "alu_model.svh"

	alu #(
		.nrm_gain (nrm_gain)
	) i_alu (
		.clk    (clk),
		.arst_n (arst_n),
		.op     (op),
		.in1    (in1),
		.in2    (in2),
		.result (result)
	);

	always #50 clk = ~clk;                      // 100 ns period

	// ***********************************************************************
	// Compare tasks
	// ***********************************************************************

	task automatic check_int(alu_op_e o, alu_word_u got, alu_word_u exp);
		if (got.i !== exp.i) begin
			int_errors++;
			$display("error at %0t ns: op %s (%0d) gave %h, expected %h",
				$time, o.name(), o, got.i, exp.i);
		end
	endtask

	task automatic check_float(alu_op_e o, alu_word_u got, alu_word_u exp);
		if (got.f.sign !== exp.f.sign || got.f.exp !== exp.f.exp || got.f.man !== exp.f.man) begin
			float_errors++;
			$display("error at %0t ns: op %s (%0d) gave %b/%0d/%h, expected %b/%0d/%h",
				$time, o.name(), o, got.f.sign, got.f.exp, got.f.man,
				exp.f.sign, exp.f.exp, exp.f.man);
		end
	endtask

	// ***********************************************************************
	// Stimulus helpers
	// ***********************************************************************

	task automatic pick_op(output alu_op_e o);
		if ($unsigned($random(seed)) % 16 == 0)
			o = alu_op_e'(spare_codes[$unsigned($random(seed)) % 8]);   // Unassigned
		else
			o = kept_ops[$unsigned($random(seed)) % 40];
	endtask

	task automatic make_operands(input alu_op_e o, output alu_word_u a, output alu_word_u b);
		int mode;
		a.i  = $random(seed);
		b.i  = $random(seed);
		mode = $unsigned($random(seed)) % 8;
		case (mode)
			0: b.i = 0;                         // Zero divisor, false operand
			1: a.i = 0;
			2: begin
				a.i = $random(seed) % 200;      // Small signed values
				b.i = $random(seed) % 200;
			end
			default: ;
		endcase
		if (o inside {shl, shr, srs} && mode != 3)
			b.i = $unsigned($random(seed)) % 40;    // Around the 32 limit
		if (is_float_op(o) || o inside {f_les, f_gre}) begin
			if (mode == 4)
				b.f = '{sign: ~a.f.sign, exp: a.f.exp, man: a.f.man};  // Sum cancels
			else if (mode >= 5)
				b.f.exp = a.f.exp + 8'($random(seed) % 6);              // Close exponents
		end
	endtask

	// ***********************************************************************
	// Watchdog and main sequence
	// ***********************************************************************

	initial begin : watchdog
		#((reset_cycles + n_ops + 10) * 100);
		$display("Timeout: the operations did not all complete in time");
		$display("sim failed");
		$finish;
	end

	initial begin : stimulus
		alu_word_u exp_word, zero_word, a, b;
		alu_op_e   exp_op, o;
		logic      pending;
		int        d;
		seed         = 32'h0bef_deff;
		int_errors   = 0;
		float_errors = 0;
		arst_n       = 1'b0;
		op           = nop;
		in1          = '0;
		in2          = '0;
		zero_word    = '0;
		pending      = 1'b0;
		for (int c = 0; c < reset_cycles + n_ops - 1; c++) begin
			@(negedge clk);
			if (!pending)
				check_int(op, result, zero_word);       // Held at zero in reset
			else if (is_float_op(exp_op))
				check_float(exp_op, result, exp_word);
			else
				check_int(exp_op, result, exp_word);
			if (c == reset_cycles - 1)
				arst_n = 1'b1;
			d = c - (reset_cycles - 1);
			if (d >= 0 && d < n_directed) begin
				if (d % 4 == 3)
					o = alu_op_e'(spare_codes[d % 8]);
				else
					o = (d % 2 == 1) ? lod : nop;
			end else begin
				pick_op(o);
			end
			make_operands(o, a, b);
			op       = o;
			in1      = a;
			in2      = b;
			exp_op   = o;
			exp_word = expected_word(o, a, b);
			pending  = arst_n;
		end
		@(negedge clk);                             // Last result
		if (is_float_op(exp_op))
			check_float(exp_op, result, exp_word);
		else
			check_int(exp_op, result, exp_word);
		$display("Errors: %0d integer, %0d float", int_errors, float_errors);
		if (int_errors + float_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+verif
design/alu_pkg.sv
design/alu_int_arith.sv
design/alu_logic.sv
design/alu_float_align.sv
design/alu_float_norm.sv
design/alu_float_arith.sv
design/alu_result_reg.sv
design/alu.sv
verif/tb_alu.sv
